// File: design/cpu_decode_defines.svh
`ifndef CPU_DECODE_DEFINES_SVH
`define CPU_DECODE_DEFINES_SVH

// Physical register file of the core.
// r0-r15 come first, then the banked copies for FIQ, IRQ, SVC, ABT and UND.
`define DEC_PHY_REGS            46

// Width of a physical register index.
`define DEC_PHY_IDX_W           6

// Width of an architectural register index, r0 to r15.
`define DEC_ARCH_IDX_W          4

// Writes to the top physical entry are thrown away.
`define DEC_RAZ_INDEX           (`DEC_PHY_REGS - 1)

// PC plus 8 seen by the execute stage while the pipe holds a bubble.
`define DEC_RESET_PC8           8

`endif

// File: design/isa_pkg.sv
`default_nettype none

`include "cpu_decode_defines.svh"

package isa_pkg;

////////////////////////////////////////
// Condition codes.
////////////////////////////////////////

// NV never executes, so the pipeline uses it to mark a bubble.
typedef enum logic [3:0] {
        COND_EQ = 4'h0,
        COND_NE = 4'h1,
        COND_CS = 4'h2,
        COND_CC = 4'h3,
        COND_MI = 4'h4,
        COND_PL = 4'h5,
        COND_VS = 4'h6,
        COND_VC = 4'h7,
        COND_HI = 4'h8,
        COND_LS = 4'h9,
        COND_GE = 4'hA,
        COND_LT = 4'hB,
        COND_GT = 4'hC,
        COND_LE = 4'hD,
        COND_AL = 4'hE,
        COND_NV = 4'hF
} cond_t;

////////////////////////////////////////
// Data processing and shifter.
////////////////////////////////////////

// Encoded as in bits 24:21 of a data-processing instruction.
typedef enum logic [3:0] {
        ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB,
        ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
        ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN,
        ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
} alu_op_t;

// RORI is the rotate of an 8-bit immediate. It behaves like ROR but
// the carry out follows the immediate rules.
typedef enum logic [2:0] {
        SH_LSL  = 3'd0,
        SH_LSR  = 3'd1,
        SH_ASR  = 3'd2,
        SH_ROR  = 3'd3,
        SH_RORI = 3'd4
} shift_t;

////////////////////////////////////////
// Processor state.
////////////////////////////////////////

typedef enum logic [4:0] {
        MODE_USR = 5'h10,
        MODE_FIQ = 5'h11,
        MODE_IRQ = 5'h12,
        MODE_SVC = 5'h13,
        MODE_ABT = 5'h17,
        MODE_UND = 5'h1B,
        MODE_SYS = 5'h1F
} cpu_mode_t;

// Interrupt mask bits in the CPSR.
localparam int unsigned CPSR_I_BIT = 7;
localparam int unsigned CPSR_F_BIT = 6;

typedef logic [`DEC_ARCH_IDX_W-1:0] arch_idx_t;
typedef logic [`DEC_PHY_IDX_W-1:0]  phy_idx_t;

endpackage

`default_nettype wire

// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

import isa_pkg::*;

// Operand to the ALU or the shifter.
// Bit 32 set means the low word is an immediate, else it holds a register index.
typedef logic [32:0] operand_t;

localparam int unsigned OPERAND_IMM_BIT = 32;

// Control fields of one decoded instruction.
// Index fields are wide enough for a physical index, so the same type
// carries the fields before and after the bank translation.
typedef struct packed {
        cond_t          cond;
        phy_idx_t       dest_index;
        operand_t       alu_source;
        alu_op_t        alu_op;
        operand_t       shift_source;
        shift_t         shift_op;
        operand_t       shift_length;
        logic           flag_update;
        phy_idx_t       mem_srcdest_index;
        logic           mem_load;
        logic           mem_store;
        logic           mem_pre_index;
        logic           mem_unsigned_byte_enable;
        logic           mem_translate;
        logic           und;
        logic           swi;
} decoded_t;

// Contents of the decode stage register.
// The und flag inside dec is already qualified by the valid level.
typedef struct packed {
        decoded_t       dec;
        logic [31:0]    pc;
        logic [31:0]    pc_plus_8;
        logic [1:0]     taken;
        logic           irq;
        logic           fiq;
        logic           abt;
} stage_out_t;

endpackage

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_decode_defines.svh"

module instr_decoder
        import isa_pkg::*;
        import pipe_pkg::*;
(
        input  wire [31:0]      i_instruction,
        input  wire             i_instruction_valid,
        output decoded_t        o_decoded
);

function automatic operand_t reg_operand(input arch_idx_t idx);
        return operand_t'(idx);
endfunction

function automatic operand_t imm_operand(input logic [31:0] value);
        return {1'b1, value};
endfunction

localparam phy_idx_t RAZ = phy_idx_t'(`DEC_RAZ_INDEX);

arch_idx_t      rn;
arch_idx_t      rd;
arch_idx_t      rm;
logic           p_bit;
logic           u_bit;
logic           b_bit;
logic           w_bit;
logic           l_bit;

assign rn    = i_instruction[19:16];
assign rd    = i_instruction[15:12];
assign rm    = i_instruction[3:0];
assign p_bit = i_instruction[24];
assign u_bit = i_instruction[23];
assign b_bit = i_instruction[22];
assign w_bit = i_instruction[21];
assign l_bit = i_instruction[20];

always_comb
begin
        o_decoded                   = '0;
        o_decoded.cond              = i_instruction_valid ?
                                      cond_t'(i_instruction[31:28]) : COND_NV;
        o_decoded.dest_index        = RAZ;
        o_decoded.mem_srcdest_index = RAZ;

        case (i_instruction[27:25])
        ////////////////////////////////////////
        // Data processing.
        ////////////////////////////////////////
        3'b000, 3'b001:
        begin
                // Register shifts, multiplies and halfword moves are not decoded here.
                if (!i_instruction[25] && i_instruction[4])
                begin
                        o_decoded.und = 1'b1;
                end
                else
                begin
                        o_decoded.dest_index  = phy_idx_t'(rd);
                        o_decoded.alu_source  = reg_operand(rn);
                        o_decoded.alu_op      = alu_op_t'(i_instruction[24:21]);
                        o_decoded.flag_update = i_instruction[20];

                        if (i_instruction[25])
                        begin
                                // imm8 rotated right by twice the rotate field.
                                o_decoded.shift_source =
                                        imm_operand({24'd0, i_instruction[7:0]});
                                o_decoded.shift_op     = SH_RORI;
                                o_decoded.shift_length =
                                        imm_operand({27'd0, i_instruction[11:8], 1'b0});
                        end
                        else
                        begin
                                o_decoded.shift_source = reg_operand(rm);
                                o_decoded.shift_op     =
                                        shift_t'({1'b0, i_instruction[6:5]});
                                o_decoded.shift_length =
                                        imm_operand({27'd0, i_instruction[11:7]});
                        end
                end
        end

        ////////////////////////////////////////
        // Load/store with immediate offset.
        ////////////////////////////////////////
        3'b010:
        begin
                // Base register writeback on post-index or when W is set.
                if (!p_bit || w_bit)
                begin
                        o_decoded.dest_index = phy_idx_t'(rn);
                end
                o_decoded.alu_source               = reg_operand(rn);
                o_decoded.alu_op                   = u_bit ? ALU_ADD : ALU_SUB;
                o_decoded.shift_source             =
                        imm_operand({20'd0, i_instruction[11:0]});
                o_decoded.shift_op                 = SH_LSL;
                o_decoded.shift_length             = imm_operand(32'd0);
                o_decoded.mem_srcdest_index        = phy_idx_t'(rd);
                o_decoded.mem_load                 = l_bit;
                o_decoded.mem_store                = !l_bit;
                o_decoded.mem_pre_index            = p_bit;
                o_decoded.mem_unsigned_byte_enable = b_bit;
                o_decoded.mem_translate            = !p_bit && w_bit;
        end

        3'b111:
        begin
                // Coprocessor space is undefined, SWI is 1111.
                o_decoded.swi = i_instruction[24];
                o_decoded.und = !i_instruction[24];
        end

        default:
        begin
                o_decoded.und = 1'b1;
        end
        endcase
end

endmodule

`default_nettype wire

// File: design/reg_bank_map.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank_map
        import isa_pkg::*;
        import pipe_pkg::*;
(
        input  wire decoded_t   i_decoded,
        input  wire cpu_mode_t  i_mode,
        output decoded_t        o_decoded
);

// Banked copies follow r15 in the physical file, FIQ r8-r14 first.
// Indices above r15 are already physical and pass unchanged.
function automatic phy_idx_t map_index(input phy_idx_t idx, input cpu_mode_t mode);
        phy_idx_t banked;

        banked = idx;
        case (mode)
        MODE_FIQ: if (idx >= 8 && idx <= 14) banked = idx + 6'd8;
        MODE_IRQ: if (idx == 13 || idx == 14) banked = idx + 6'd10;
        MODE_SVC: if (idx == 13 || idx == 14) banked = idx + 6'd12;
        MODE_ABT: if (idx == 13 || idx == 14) banked = idx + 6'd14;
        MODE_UND: if (idx == 13 || idx == 14) banked = idx + 6'd16;
        default:  banked = idx; // USR, SYS and unknown modes.
        endcase
        return banked;
endfunction

function automatic operand_t map_operand(input operand_t op, input cpu_mode_t mode);
        if (op[OPERAND_IMM_BIT])
        begin
                return op;
        end
        return operand_t'(map_index(phy_idx_t'(op), mode));
endfunction

always_comb
begin
        o_decoded                   = i_decoded;
        o_decoded.dest_index        = map_index(i_decoded.dest_index, i_mode);
        o_decoded.mem_srcdest_index = map_index(i_decoded.mem_srcdest_index, i_mode);
        o_decoded.alu_source        = map_operand(i_decoded.alu_source, i_mode);
        o_decoded.shift_source      = map_operand(i_decoded.shift_source, i_mode);
        o_decoded.shift_length      = map_operand(i_decoded.shift_length, i_mode);
end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_decode_defines.svh"

module decode_stage
        import isa_pkg::*;
        import pipe_pkg::*;
(
        input  wire             i_clk,
        input  wire             i_reset,

        input  wire decoded_t   i_decoded,
        input  wire [31:0]      i_cpsr,
        input  wire             i_instruction_valid,

        input  wire [31:0]      i_pc,
        input  wire [31:0]      i_pc_plus_8,
        input  wire [1:0]       i_taken,

        input  wire             i_irq,
        input  wire             i_fiq,
        input  wire             i_abt,

        // Listed from highest to lowest priority.
        input  wire             i_clear_from_writeback,
        input  wire             i_data_stall,
        input  wire             i_clear_from_alu,
        input  wire             i_stall_from_issue,

        output stage_out_t      o_stage
);

// A bubble: never executes, writes nothing and touches no memory.
function automatic stage_out_t cleared();
        stage_out_t s;

        s                         = '0;
        s.dec.cond                = COND_NV;
        s.dec.mem_srcdest_index   = phy_idx_t'(`DEC_RAZ_INDEX);
        s.pc_plus_8               = 32'(`DEC_RESET_PC8);
        return s;
endfunction

stage_out_t stage_nxt;

////////////////////////////////////////
// Next stage contents.
////////////////////////////////////////

always_comb
begin
        stage_nxt           = '0;
        stage_nxt.dec       = i_decoded;
        stage_nxt.dec.und   = i_decoded.und && i_instruction_valid;
        stage_nxt.pc        = i_pc;
        stage_nxt.pc_plus_8 = i_pc_plus_8;
        stage_nxt.taken     = i_taken;
        // A set mask bit blocks the interrupt.
        stage_nxt.irq       = i_irq && !i_cpsr[CPSR_I_BIT];
        stage_nxt.fiq       = i_fiq && !i_cpsr[CPSR_F_BIT];
        stage_nxt.abt       = i_abt;
end

////////////////////////////////////////
// Stage register.
////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_stage <= cleared();
        end
        else if (i_clear_from_writeback)
        begin
                o_stage <= cleared();
        end
        else if (i_data_stall)
        begin
                o_stage <= o_stage;
        end
        else if (i_clear_from_alu)
        begin
                o_stage <= cleared();
        end
        else if (i_stall_from_issue)
        begin
                o_stage <= o_stage;
        end
        else
        begin
                o_stage <= stage_nxt;
        end
end

endmodule

`default_nettype wire

// File: design/decode_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module decode_subsystem
        import isa_pkg::*;
        import pipe_pkg::*;
(
        input  wire             i_clk,
        input  wire             i_reset,
        input  wire [31:0]      i_instruction,
        input  wire             i_instruction_valid,
        input  wire [31:0]      i_cpsr,
        input  wire [31:0]      i_pc,
        input  wire [31:0]      i_pc_plus_8,
        input  wire [1:0]       i_taken,
        input  wire             i_irq,
        input  wire             i_fiq,
        input  wire             i_abt,
        input  wire             i_clear_from_writeback,
        input  wire             i_data_stall,
        input  wire             i_clear_from_alu,
        input  wire             i_stall_from_issue,
        output stage_out_t      o_stage
);

// Decoder output, architectural indices.
decoded_t arch_decoded;

// Same fields after banking, physical indices.
decoded_t phy_decoded;

instr_decoder instr_decoder_inst (
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .o_decoded              (arch_decoded)
);

reg_bank_map reg_bank_map_inst (
        .i_decoded              (arch_decoded),
        .i_mode                 (cpu_mode_t'(i_cpsr[4:0])),
        .o_decoded              (phy_decoded)
);

decode_stage decode_stage_inst (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_decoded              (phy_decoded),
        .i_cpsr                 (i_cpsr),
        .i_instruction_valid    (i_instruction_valid),
        .i_pc                   (i_pc),
        .i_pc_plus_8            (i_pc_plus_8),
        .i_taken                (i_taken),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_abt                  (i_abt),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_issue     (i_stall_from_issue),
        .o_stage                (o_stage)
);

endmodule

`default_nettype wire

// File: tests/decode_subsystem_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_decode_defines.svh"

module decode_stage_sva
        import isa_pkg::*;
        import pipe_pkg::*;
(
        input  wire             i_clk,
        input  wire             i_reset,
        input  wire             i_clear_from_writeback,
        input  wire             i_data_stall,
        input  wire             i_clear_from_alu,
        input  wire             i_stall_from_issue,
        input  wire stage_out_t i_stage
);

logic clear_now;
logic hold_now;

// A clear from the ALU is shadowed by a data stall.
assign clear_now = i_clear_from_writeback || (!i_data_stall && i_clear_from_alu);
assign hold_now  = !i_reset && !i_clear_from_writeback &&
                   (i_data_stall || (!i_clear_from_alu && i_stall_from_issue));

clear_gives_bubble: assert property (@(posedge i_clk)
        clear_now |=> i_stage.dec.cond == COND_NV)
        else $error("clear did not leave a bubble in the decode stage");

stall_holds_stage: assert property (@(posedge i_clk)
        hold_now |=> $stable(i_stage))
        else $error("decode stage changed under a stall");

reset_parks_mem_index: assert property (@(posedge i_clk)
        i_reset |=> i_stage.dec.mem_srcdest_index == phy_idx_t'(`DEC_RAZ_INDEX))
        else $error("memory index is not the discard register after reset");

endmodule

bind decode_stage decode_stage_sva decode_stage_sva_inst (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_stage                (o_stage)
);

`default_nettype wire

// File: tests/decode_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_decode_defines.svh"

module decode_subsystem_tb
        import isa_pkg::*;
        import pipe_pkg::*;
();

localparam string       VECTOR_FILE   = "tests/decode_vectors.txt";
localparam int unsigned MAX_LINES     = 1000;
localparam int unsigned RESET_TIMEOUT = 20;

logic           clk;
logic           reset;
logic [31:0]    instruction;
logic           instruction_valid;
logic [31:0]    cpsr;
logic [31:0]    pc;
logic [31:0]    pc_plus_8;
logic [1:0]     taken;
logic           irq;
logic           fiq;
logic           abt;
logic           clear_from_writeback;
logic           data_stall;
logic           clear_from_alu;
logic           stall_from_issue;
stage_out_t     stage;

int             check_count;
int             value_errors;
int             other_errors;
int             line_no;

// One vector line, inputs first.
logic [3:0]     v_ctl;
logic [31:0]    v_instr;
logic           v_valid;
logic [31:0]    v_cpsr;
logic [31:0]    v_pc;
logic [31:0]    v_pc8;
logic [1:0]     v_taken;
logic [2:0]     v_int;
logic [3:0]     e_cond;
logic [5:0]     e_dest;
logic [32:0]    e_alu_src;
logic [3:0]     e_alu_op;
logic [32:0]    e_sh_src;
logic [2:0]     e_sh_op;
logic [32:0]    e_sh_len;
logic           e_s;
logic [5:0]     e_mem;
logic [4:0]     e_ldst;
logic [4:0]     e_exc;
logic [31:0]    e_pc;
logic [31:0]    e_pc8;
logic [1:0]     e_taken;

decode_subsystem decode_subsystem_inst (
        .i_clk                  (clk),
        .i_reset                (reset),
        .i_instruction          (instruction),
        .i_instruction_valid    (instruction_valid),
        .i_cpsr                 (cpsr),
        .i_pc                   (pc),
        .i_pc_plus_8            (pc_plus_8),
        .i_taken                (taken),
        .i_irq                  (irq),
        .i_fiq                  (fiq),
        .i_abt                  (abt),
        .i_clear_from_writeback (clear_from_writeback),
        .i_data_stall           (data_stall),
        .i_clear_from_alu       (clear_from_alu),
        .i_stall_from_issue     (stall_from_issue),
        .o_stage                (stage)
);

initial
begin
        clk = 1'b0;
        forever
        begin
                #5 clk = ~clk;
        end
end

task automatic compare_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
        check_count++;
        if (actual !== expected)
        begin
                value_errors++;
                $display("error %s: got %h, expected %h (line %0d)",
                         name, actual, expected, line_no);
        end
endtask

////////////////////////////////////////
// Output checks.
////////////////////////////////////////

task automatic check_reset_state();
        compare_value("mem_srcdest_index", 64'(stage.dec.mem_srcdest_index),
                      64'(`DEC_RAZ_INDEX));
        compare_value("pc_plus_8", 64'(stage.pc_plus_8), 64'(`DEC_RESET_PC8));
        compare_value("dest_index", 64'(stage.dec.dest_index), 64'd0);
        compare_value("flag_update", 64'(stage.dec.flag_update), 64'd0);
        compare_value("mem_flags", 64'({stage.dec.mem_load, stage.dec.mem_store,
                      stage.dec.mem_pre_index, stage.dec.mem_unsigned_byte_enable,
                      stage.dec.mem_translate}), 64'd0);
        compare_value("exc_flags", 64'({stage.irq, stage.fiq, stage.abt,
                      stage.dec.und, stage.dec.swi}), 64'd0);
endtask

task automatic check_outputs();
        compare_value("cond", 64'(stage.dec.cond), 64'(e_cond));
        compare_value("dest_index", 64'(stage.dec.dest_index), 64'(e_dest));
        compare_value("alu_source", 64'(stage.dec.alu_source), 64'(e_alu_src));
        compare_value("alu_op", 64'(stage.dec.alu_op), 64'(e_alu_op));
        compare_value("shift_source", 64'(stage.dec.shift_source), 64'(e_sh_src));
        compare_value("shift_op", 64'(stage.dec.shift_op), 64'(e_sh_op));
        compare_value("shift_length", 64'(stage.dec.shift_length), 64'(e_sh_len));
        compare_value("flag_update", 64'(stage.dec.flag_update), 64'(e_s));
        compare_value("mem_srcdest_index", 64'(stage.dec.mem_srcdest_index), 64'(e_mem));
        compare_value("mem_flags", 64'({stage.dec.mem_load, stage.dec.mem_store,
                      stage.dec.mem_pre_index, stage.dec.mem_unsigned_byte_enable,
                      stage.dec.mem_translate}), 64'(e_ldst));
        compare_value("exc_flags", 64'({stage.irq, stage.fiq, stage.abt,
                      stage.dec.und, stage.dec.swi}), 64'(e_exc));
        compare_value("pc", 64'(stage.pc), 64'(e_pc));
        compare_value("pc_plus_8", 64'(stage.pc_plus_8), 64'(e_pc8));
        compare_value("taken", 64'(stage.taken), 64'(e_taken));
endtask

// Called on a falling edge; returns on the next one, after the stage has loaded.
task automatic run_vector(input string text);
        int fields;

        fields = $sscanf(text,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                v_ctl, v_instr, v_valid, v_cpsr, v_pc, v_pc8, v_taken, v_int,
                e_cond, e_dest, e_alu_src, e_alu_op, e_sh_src, e_sh_op, e_sh_len,
                e_s, e_mem, e_ldst, e_exc, e_pc, e_pc8, e_taken);
        if (fields != 22)
        begin
                $display("Vector line %0d could not be read, only %0d of 22 fields found.",
                         line_no, fields);
                other_errors++;
        end
        else
        begin
                {clear_from_writeback, data_stall, clear_from_alu, stall_from_issue} = v_ctl;
                {irq, fiq, abt} = v_int;
                instruction       = v_instr;
                instruction_valid = v_valid;
                cpsr              = v_cpsr;
                pc                = v_pc;
                pc_plus_8         = v_pc8;
                taken             = v_taken;
                @(posedge clk);
                @(negedge clk);
                check_outputs();
        end
endtask

initial
begin
        int             fd;
        int             code;
        int unsigned    wait_cycles;
        bit             finished;
        string          line;

        check_count  = 0;
        value_errors = 0;
        other_errors = 0;
        line_no      = 0;

        reset                = 1'b1;
        instruction          = '0;
        instruction_valid    = 1'b0;
        cpsr                 = '0;
        pc                   = '0;
        pc_plus_8            = '0;
        taken                = '0;
        irq                  = 1'b0;
        fiq                  = 1'b0;
        abt                  = 1'b0;
        clear_from_writeback = 1'b0;
        data_stall           = 1'b0;
        clear_from_alu       = 1'b0;
        stall_from_issue     = 1'b0;

        repeat (2) @(posedge clk);

        // The stage must show a bubble before reset is released.
        wait_cycles = 0;
        @(negedge clk);
        while (stage.dec.cond !== COND_NV && wait_cycles < RESET_TIMEOUT)
        begin
                @(negedge clk);
                wait_cycles++;
        end

        if (stage.dec.cond !== COND_NV)
        begin
                $display("Timed out waiting for the decode stage to clear under reset.");
                other_errors++;
        end
        else
        begin
                check_reset_state();
                fd = $fopen(VECTOR_FILE, "r");
                if (fd == 0)
                begin
                        $display("Could not open the vector file %s.", VECTOR_FILE);
                        other_errors++;
                end
                else
                begin
                        reset    = 1'b0;
                        finished = 1'b0;
                        while (!finished)
                        begin
                                code = $fgets(line, fd);
                                line_no++;
                                if (code == 0)
                                begin
                                        finished = 1'b1;
                                end
                                else if (line_no > MAX_LINES)
                                begin
                                        $display("Vector file has more than %0d lines.",
                                                 MAX_LINES);
                                        other_errors++;
                                        finished = 1'b1;
                                end
                                else if (line.len() > 1 && line.getc(0) != "#")
                                begin
                                        run_vector(line);
                                end
                        end
                        $fclose(fd);
                end
        end

        $display("checks %0d, value errors %0d, other errors %0d",
                 check_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0 && check_count > 0)
        begin
                $display("Simulation finished: PASS");
        end
        else
        begin
                $display("Simulation finished: FAIL");
        end
        $finish;
end

endmodule

`default_nettype wire

// File: tests/decode_vectors.txt
# ctl(wb dstall aluclr istall) instr valid cpsr pc pc8 taken int(irq fiq abt) | expected: cond dest
# alu_src alu_op sh_src sh_op sh_len s mem ldst(ld st pre byte trans) exc(irq fiq abt und swi) pc pc8 taken
0 e292123f 1 00000010 00000100 00000108 0 0  e 01 000000002 4 10000003f 4 100000004 1 2d 00 00 00000100 00000108 0
0 000433c5 1 00000010 00000104 0000010c 1 0  0 03 000000004 0 000000005 2 100000007 0 2d 00 00 00000104 0000010c 1
0 e5d76123 1 00000010 00000108 00000110 0 0  e 2d 000000007 4 100000123 0 100000000 0 06 16 00 00000108 00000110 0
0 e4232010 1 00000010 0000010c 00000114 2 0  e 03 000000003 2 100000010 0 100000000 0 02 09 00 0000010c 00000114 2
0 e08ed009 1 00000010 00000110 00000118 0 0  e 0d 00000000e 4 000000009 0 100000000 0 2d 00 00 00000110 00000118 0
0 e08ed009 1 00000011 00000114 0000011c 0 0  e 15 000000016 4 000000011 0 100000000 0 2d 00 00 00000114 0000011c 0
0 e08ed009 1 00000012 00000118 00000120 0 0  e 17 000000018 4 000000009 0 100000000 0 2d 00 00 00000118 00000120 0
0 e08ed009 1 00000013 0000011c 00000124 0 0  e 19 00000001a 4 000000009 0 100000000 0 2d 00 00 0000011c 00000124 0
0 e5dd8123 1 00000011 00000120 00000128 0 0  e 2d 000000015 4 100000123 0 100000000 0 10 16 00 00000120 00000128 0
0 e292123f 1 00000010 00000124 0000012c 3 0  e 01 000000002 4 10000003f 4 100000004 1 2d 00 00 00000124 0000012c 3
c 000433c5 1 00000010 00000128 00000130 1 0  f 00 000000000 0 000000000 0 000000000 0 2d 00 00 00000000 00000008 0
0 000433c5 1 00000010 0000012c 00000134 1 0  0 03 000000004 0 000000005 2 100000007 0 2d 00 00 0000012c 00000134 1
6 e292123f 1 00000010 00000130 00000138 0 0  0 03 000000004 0 000000005 2 100000007 0 2d 00 00 0000012c 00000134 1
2 e292123f 1 00000010 00000134 0000013c 0 0  f 00 000000000 0 000000000 0 000000000 0 2d 00 00 00000000 00000008 0
0 e292123f 1 00000010 00000138 00000140 2 0  e 01 000000002 4 10000003f 4 100000004 1 2d 00 00 00000138 00000140 2
1 000433c5 1 00000010 0000013c 00000144 1 0  e 01 000000002 4 10000003f 4 100000004 1 2d 00 00 00000138 00000140 2
0 e6000010 0 00000010 00000140 00000148 0 0  f 2d 000000000 0 000000000 0 000000000 0 2d 00 00 00000140 00000148 0
0 e7f000f0 1 00000010 00000144 0000014c 0 0  e 2d 000000000 0 000000000 0 000000000 0 2d 00 02 00000144 0000014c 0
0 ef000011 1 00000010 00000148 00000150 0 0  e 2d 000000000 0 000000000 0 000000000 0 2d 00 01 00000148 00000150 0
0 ee000000 1 00000010 0000014c 00000154 0 0  e 2d 000000000 0 000000000 0 000000000 0 2d 00 02 0000014c 00000154 0
0 e292123f 1 00000010 00000150 00000158 0 6  e 01 000000002 4 10000003f 4 100000004 1 2d 00 18 00000150 00000158 0
0 e292123f 1 00000090 00000154 0000015c 0 6  e 01 000000002 4 10000003f 4 100000004 1 2d 00 08 00000154 0000015c 0
0 e292123f 1 00000050 00000158 00000160 0 7  e 01 000000002 4 10000003f 4 100000004 1 2d 00 14 00000158 00000160 0
0 e292123f 1 000000d0 0000015c 00000164 0 7  e 01 000000002 4 10000003f 4 100000004 1 2d 00 04 0000015c 00000164 0

// File: decode_subsystem.f
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/instr_decoder.sv
design/reg_bank_map.sv
design/decode_stage.sv
design/decode_subsystem.sv
tests/decode_subsystem_sva.sv
tests/decode_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode subsystem testbench with Verilator.
# The run fails when the log holds the fail message or a step fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=decode_subsystem_tb

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module "$TOP" -f decode_subsystem.f
status=$?
if [ "$status" -ne 0 ]; then
        echo "run_sim: Verilator build failed with status $status"
        exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
        echo "run_sim: simulation exited with status $status"
        exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
        echo "run_sim: testbench reported failure"
        exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
        echo "run_sim: no result line in $LOG"
        exit 1
fi

echo "run_sim: testbench passed"
exit 0
